// File: verilog/cga_pkg.sv
package cga_pkg;

  // Datapath and register file
  localparam int DATA_W = 16;
  localparam int REG_AW = 4;
  localparam int NREGS  = 16;

  // Interrupt lines 10, 11, 12, 13 and 15 map to index 0 to 4
  localparam int INT_LEVELS = 5;
  localparam int PICS_W     = 3;

  // Test port
  localparam int TEST_W = 5;
  localparam int TSEL_W = 3;

  localparam logic [TSEL_W-1:0] TSEL_FLAGS  = 3'd0; // z, cry, ovf, mi, intrq_n
  localparam logic [TSEL_W-1:0] TSEL_RESULT = 3'd1; // Low bits of fidbo
  localparam logic [TSEL_W-1:0] TSEL_PICS   = 3'd2; // Priority code

  // ALU functions
  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,
    ALU_SUB   = 3'd1, // A minus B
    ALU_AND   = 3'd2,
    ALU_OR    = 3'd3,
    ALU_XOR   = 3'd4,
    ALU_PASSA = 3'd5,
    ALU_PASSB = 3'd6,
    ALU_INC   = 3'd7  // A plus one
  } alu_op_t;

  // B-operand source, code 3 is reserved and gives zero
  typedef enum logic [1:0] {
    BSEL_REG = 2'd0,
    BSEL_CD  = 2'd1,
    BSEL_BUS = 2'd2
  } bsel_t;

endpackage

// File: verilog/cga_wrf.sv
`timescale 1ns/1ps

module cga_wrf import cga_pkg::*; (
  input  logic              sysclk,
  input  logic              arst_n,
  input  logic              cs_valid,
  input  alu_op_t           cs_op,
  input  logic [REG_AW-1:0] cs_ra,
  input  logic [REG_AW-1:0] cs_rb,
  input  bsel_t             cs_bsel,
  input  logic [DATA_W-1:0] cs_cd,
  input  logic              cs_wr,
  input  logic              cs_ldmask,
  input  logic [DATA_W-1:0] xfidb_in,
  input  logic              wb_en,
  input  logic [REG_AW-1:0] wb_addr,
  input  logic [DATA_W-1:0] wb_data,
  output logic              op_valid,
  output alu_op_t           op_code,
  output logic [DATA_W-1:0] op_a,
  output logic [DATA_W-1:0] op_b,
  output logic [REG_AW-1:0] op_dest,
  output logic              op_wr,
  output logic              op_ldmask
);

  logic [DATA_W-1:0] regs [NREGS];
  logic [DATA_W-1:0] rd_a;
  logic [DATA_W-1:0] b_sel;

  // Working registers, single write port from the execute stage
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NREGS; i++) regs[i] <= '0;
    end else if (wb_en) begin
      regs[wb_addr] <= wb_data;
    end
  end

  assign rd_a = regs[cs_ra];

  // B source mux
  always_comb begin
    case (cs_bsel)
      BSEL_REG: b_sel = regs[cs_rb];
      BSEL_CD:  b_sel = cs_cd;
      BSEL_BUS: b_sel = xfidb_in;
      default:  b_sel = '0; // Reserved
    endcase
  end

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      op_valid  <= 1'b0;
      op_wr     <= 1'b0;
      op_ldmask <= 1'b0;
    end else begin
      op_valid  <= cs_valid;
      op_wr     <= cs_valid & cs_wr;
      op_ldmask <= cs_valid & cs_ldmask;
    end
  end

  // Operand payload, held between microwords
  always_ff @(posedge sysclk) begin
    if (cs_valid) begin
      op_code <= cs_op;
      op_a    <= rd_a;
      op_b    <= b_sel;
      op_dest <= cs_rb;  // Destination is the B register address
    end
  end

endmodule

// File: verilog/cga_alu.sv
`timescale 1ns/1ps

module cga_alu import cga_pkg::*; (
  input  logic                  sysclk,
  input  logic                  arst_n,
  input  logic                  op_valid,
  input  alu_op_t               op_code,
  input  logic [DATA_W-1:0]     op_a,
  input  logic [DATA_W-1:0]     op_b,
  input  logic [REG_AW-1:0]     op_dest,
  input  logic                  op_wr,
  input  logic                  op_ldmask,
  output logic [DATA_W-1:0]     fidbo,
  output logic                  z,
  output logic                  cry,
  output logic                  ovf,
  output logic                  mi,
  output logic                  wb_en,
  output logic [REG_AW-1:0]     wb_addr,
  output logic [DATA_W-1:0]     wb_data,
  output logic                  mask_ld,
  output logic [INT_LEVELS-1:0] mask_data
);

  logic [DATA_W:0]   sum;  // One extra bit for carry or borrow
  logic [DATA_W-1:0] res;
  logic              c_nxt;
  logic              v_nxt;

  always_comb begin
    sum   = '0;
    res   = '0;
    c_nxt = 1'b0;
    v_nxt = 1'b0;
    case (op_code)
      ALU_ADD: begin
        sum   = {1'b0, op_a} + {1'b0, op_b};
        res   = sum[DATA_W-1:0];
        c_nxt = sum[DATA_W];
        v_nxt = (op_a[DATA_W-1] == op_b[DATA_W-1]) && (res[DATA_W-1] != op_a[DATA_W-1]);
      end
      ALU_SUB: begin
        sum   = {1'b0, op_a} - {1'b0, op_b};
        res   = sum[DATA_W-1:0];
        c_nxt = sum[DATA_W];  // Borrow
        v_nxt = (op_a[DATA_W-1] != op_b[DATA_W-1]) && (res[DATA_W-1] != op_a[DATA_W-1]);
      end
      ALU_INC: begin
        sum   = {1'b0, op_a} + 1'b1;
        res   = sum[DATA_W-1:0];
        c_nxt = sum[DATA_W];
        v_nxt = !op_a[DATA_W-1] && res[DATA_W-1];
      end
      ALU_AND:   res = op_a & op_b;
      ALU_OR:    res = op_a | op_b;
      ALU_XOR:   res = op_a ^ op_b;
      ALU_PASSA: res = op_a;
      ALU_PASSB: res = op_b;
      default:   res = '0;
    endcase
  end

  // Result and flags hold until the next valid operation
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      fidbo <= '0;
      z     <= 1'b0;
      cry   <= 1'b0;
      ovf   <= 1'b0;
      mi    <= 1'b0;
    end else if (op_valid) begin
      fidbo <= res;
      z     <= (res == '0);
      cry   <= c_nxt;
      ovf   <= v_nxt;
      mi    <= res[DATA_W-1];
    end
  end

  // Write-back and mask load strobes, consumed one edge later
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      wb_en   <= 1'b0;
      mask_ld <= 1'b0;
    end else begin
      wb_en   <= op_valid & op_wr;
      mask_ld <= op_valid & op_ldmask;
    end
  end

  always_ff @(posedge sysclk) begin
    if (op_valid) wb_addr <= op_dest;
  end

  assign wb_data   = fidbo;
  assign mask_data = fidbo[INT_LEVELS-1:0]; // Mask comes from the result low bits

endmodule

// File: verilog/cga_intr.sv
`timescale 1ns/1ps

module cga_intr import cga_pkg::*; (
  input  logic                  sysclk,
  input  logic                  arst_n,
  input  logic [INT_LEVELS-1:0] bint_n,
  input  logic                  mask_ld,
  input  logic [INT_LEVELS-1:0] mask_data,
  input  logic                  clirq,
  output logic                  intrq_n,
  output logic [PICS_W-1:0]     pics
);

  logic [INT_LEVELS-1:0] pending;
  logic [INT_LEVELS-1:0] mask;
  logic [INT_LEVELS-1:0] active;
  logic [INT_LEVELS-1:0] clr;
  logic [PICS_W-1:0]     pics_nxt;

  // Only clear while a level is actually being requested
  assign clr    = (clirq && !intrq_n) ? (INT_LEVELS'(1) << pics) : '0;
  assign active = pending & mask;

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= '0;
      mask    <= '0;
    end else begin
      pending <= (pending | ~bint_n) & ~clr; // Clear wins over a held level
      if (mask_ld) mask <= mask_data;
    end
  end

  // Highest index wins
  always_comb begin
    pics_nxt = '0;
    for (int i = 0; i < INT_LEVELS; i++) begin
      if (active[i]) pics_nxt = PICS_W'(i);
    end
  end

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      intrq_n <= 1'b1;
      pics    <= '0;
    end else begin
      intrq_n <= ~|active;
      pics    <= pics_nxt;
    end
  end

endmodule

// File: verilog/cga_pads.sv
`timescale 1ns/1ps

module cga_pads import cga_pkg::*; (
  input  logic [DATA_W-1:0] fidbo,
  input  logic [DATA_W-1:0] xfidb_in,
  input  logic              edo_n,
  input  logic              ptst_n,
  input  logic [TSEL_W-1:0] tsel,
  input  logic              z,
  input  logic              cry,
  input  logic              ovf,
  input  logic              mi,
  input  logic              intrq_n,
  input  logic [PICS_W-1:0] pics,
  output logic [DATA_W-1:0] xfidb_out,
  output logic [TEST_W-1:0] test
);

  // Bus driver, loopback has priority over the output enable
  always_comb begin
    if (!ptst_n)     xfidb_out = xfidb_in;
    else if (!edo_n) xfidb_out = fidbo;
    else             xfidb_out = '0;
  end

  // Test output mux
  always_comb begin
    case (tsel)
      TSEL_FLAGS:  test = {intrq_n, mi, ovf, cry, z};
      TSEL_RESULT: test = fidbo[TEST_W-1:0];
      TSEL_PICS:   test = {{(TEST_W-PICS_W){1'b0}}, pics};
      default:     test = '1;
    endcase
  end

endmodule

// File: verilog/cga.sv
`timescale 1ns/1ps

module cga import cga_pkg::*; (
  input  logic                  sysclk,
  input  logic                  arst_n,
  input  logic                  cs_valid,
  input  alu_op_t               cs_op,
  input  logic [REG_AW-1:0]     cs_ra,
  input  logic [REG_AW-1:0]     cs_rb,
  input  bsel_t                 cs_bsel,
  input  logic [DATA_W-1:0]     cs_cd,
  input  logic                  cs_wr,
  input  logic                  cs_ldmask,
  input  logic [DATA_W-1:0]     xfidb_in,
  output logic [DATA_W-1:0]     xfidb_out,
  input  logic                  edo_n,
  input  logic                  ptst_n,
  input  logic [INT_LEVELS-1:0] bint_n,
  input  logic                  clirq,
  output logic                  intrq_n,
  input  logic [TSEL_W-1:0]     tsel,
  output logic [TEST_W-1:0]     test
);

  // Operand stage to execute stage
  logic                  op_valid;
  alu_op_t               op_code;
  logic [DATA_W-1:0]     op_a;
  logic [DATA_W-1:0]     op_b;
  logic [REG_AW-1:0]     op_dest;
  logic                  op_wr;
  logic                  op_ldmask;

  // Execute stage outputs
  logic [DATA_W-1:0]     fidbo;
  logic                  z;
  logic                  cry;
  logic                  ovf;
  logic                  mi;
  logic                  wb_en;
  logic [REG_AW-1:0]     wb_addr;
  logic [DATA_W-1:0]     wb_data;
  logic                  mask_ld;
  logic [INT_LEVELS-1:0] mask_data;

  logic [PICS_W-1:0]     pics;

  cga_wrf wrf0 (
    .sysclk(sysclk), .arst_n(arst_n),
    .cs_valid(cs_valid), .cs_op(cs_op), .cs_ra(cs_ra), .cs_rb(cs_rb),
    .cs_bsel(cs_bsel), .cs_cd(cs_cd), .cs_wr(cs_wr), .cs_ldmask(cs_ldmask),
    .xfidb_in(xfidb_in),
    .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
    .op_valid(op_valid), .op_code(op_code), .op_a(op_a), .op_b(op_b),
    .op_dest(op_dest), .op_wr(op_wr), .op_ldmask(op_ldmask)
  );

  cga_alu alu0 (
    .sysclk(sysclk), .arst_n(arst_n),
    .op_valid(op_valid), .op_code(op_code), .op_a(op_a), .op_b(op_b),
    .op_dest(op_dest), .op_wr(op_wr), .op_ldmask(op_ldmask),
    .fidbo(fidbo), .z(z), .cry(cry), .ovf(ovf), .mi(mi),
    .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
    .mask_ld(mask_ld), .mask_data(mask_data)
  );

  cga_intr intr0 (
    .sysclk(sysclk), .arst_n(arst_n),
    .bint_n(bint_n), .mask_ld(mask_ld), .mask_data(mask_data), .clirq(clirq),
    .intrq_n(intrq_n), .pics(pics)
  );

  cga_pads pads0 (
    .fidbo(fidbo), .xfidb_in(xfidb_in), .edo_n(edo_n), .ptst_n(ptst_n),
    .tsel(tsel), .z(z), .cry(cry), .ovf(ovf), .mi(mi),
    .intrq_n(intrq_n), .pics(pics),
    .xfidb_out(xfidb_out), .test(test)
  );

endmodule

// File: test/cga_checker.sv
`timescale 1ns/1ps

module cga_checker import cga_pkg::*; (
  input logic                  sysclk,
  input logic                  arst_n,
  input logic                  cs_valid,
  input alu_op_t               cs_op,
  input logic [REG_AW-1:0]     cs_ra,
  input logic [REG_AW-1:0]     cs_rb,
  input bsel_t                 cs_bsel,
  input logic [DATA_W-1:0]     cs_cd,
  input logic                  cs_wr,
  input logic                  cs_ldmask,
  input logic [DATA_W-1:0]     xfidb_in,
  input logic [DATA_W-1:0]     xfidb_out,
  input logic                  edo_n,
  input logic                  ptst_n,
  input logic [INT_LEVELS-1:0] bint_n,
  input logic                  clirq,
  input logic                  intrq_n,
  input logic [TSEL_W-1:0]     tsel,
  input logic [TEST_W-1:0]     test,
  input logic [PICS_W-1:0]     pics
);

  logic [DATA_W-1:0]     mregs [NREGS]; // Reference working registers
  logic [DATA_W-1:0]     b_ref;
  logic [DATA_W+1:0]     s1_out;        // Ovf, cry, result
  logic                  s1_v;
  logic                  s1_wr;
  logic                  s1_ldm;
  logic [REG_AW-1:0]     s1_dest;
  logic                  s2_wr;
  logic                  s2_ldm;
  logic [REG_AW-1:0]     s2_dest;
  logic [DATA_W-1:0]     res_m;
  logic [3:0]            flags_m;       // Mi, ovf, cry, z
  logic [INT_LEVELS-1:0] mask_m;
  logic [INT_LEVELS-1:0] pend_m;
  logic [INT_LEVELS-1:0] act_m;
  logic                  intrq_m;
  logic [PICS_W-1:0]     pics_m;
  logic [PICS_W-1:0]     top_m;
  logic [TEST_W-1:0]     test_m;
  logic [DATA_W-1:0]     bus_m;
  int                    fails = 0;

  // Integer view of the ALU, carry and overflow from range checks
  function automatic logic [DATA_W+1:0] alu_ref(input alu_op_t op,
                                                input logic [DATA_W-1:0] a,
                                                input logic [DATA_W-1:0] b);
    int  ua;
    int  ub;
    int  sa;
    int  sb;
    int  ur;
    int  sr;
    logic arith;
    ua = int'(a);
    sa = int'($signed(a));
    ub = (op == ALU_INC) ? 1 : int'(b);
    sb = (op == ALU_INC) ? 1 : int'($signed(b));
    ur = 0;
    sr = 0;
    case (op)
      ALU_ADD, ALU_INC: begin
        ur = ua + ub;
        sr = sa + sb;
      end
      ALU_SUB: begin
        ur = ua - ub;
        sr = sa - sb;
      end
      ALU_AND:   ur = ua & ub;
      ALU_OR:    ur = ua | ub;
      ALU_XOR:   ur = ua ^ ub;
      ALU_PASSA: ur = ua;
      ALU_PASSB: ur = ub;
      default:   ur = 0;
    endcase
    arith = op inside {ALU_ADD, ALU_SUB, ALU_INC};
    return {arith && (sr < -32768 || sr > 32767), arith && (ur < 0 || ur > 65535),
            DATA_W'(ur)};
  endfunction

  always_comb begin
    case (cs_bsel)
      BSEL_REG: b_ref = mregs[cs_rb];
      BSEL_CD:  b_ref = cs_cd;
      BSEL_BUS: b_ref = xfidb_in;
      default:  b_ref = '0;
    endcase
  end

  // Operands at the first edge, result next, write-back and mask after that
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NREGS; i++) mregs[i] <= '0;
      s1_v    <= 1'b0;
      s1_wr   <= 1'b0;
      s1_ldm  <= 1'b0;
      s1_out  <= '0;
      s1_dest <= '0;
      s2_wr   <= 1'b0;
      s2_ldm  <= 1'b0;
      s2_dest <= '0;
      res_m   <= '0;
      flags_m <= '0;
      mask_m  <= '0;
    end else begin
      s1_v   <= cs_valid;
      s1_wr  <= cs_valid && cs_wr;
      s1_ldm <= cs_valid && cs_ldmask;
      if (cs_valid) begin
        s1_out  <= alu_ref(cs_op, mregs[cs_ra], b_ref);
        s1_dest <= cs_rb;
      end
      s2_wr  <= s1_wr;
      s2_ldm <= s1_ldm;
      if (s1_v) begin
        res_m   <= s1_out[DATA_W-1:0];
        flags_m <= {s1_out[DATA_W-1], s1_out[DATA_W+1], s1_out[DATA_W],
                    s1_out[DATA_W-1:0] == '0};
        s2_dest <= s1_dest;
      end
      if (s2_wr) mregs[s2_dest] <= res_m;
      if (s2_ldm) mask_m <= res_m[INT_LEVELS-1:0];
    end
  end

  assign act_m = pend_m & mask_m;

  always_comb begin
    top_m = '0;
    for (int i = INT_LEVELS - 1; i >= 0; i--) begin
      if (act_m[i]) begin
        top_m = PICS_W'(i);
        break;
      end
    end
  end

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      pend_m  <= '0;
      intrq_m <= 1'b1;
      pics_m  <= '0;
    end else begin
      for (int i = 0; i < INT_LEVELS; i++) begin
        if (clirq && !intrq_m && pics_m == PICS_W'(i)) pend_m[i] <= 1'b0;
        else if (!bint_n[i]) pend_m[i] <= 1'b1;
      end
      intrq_m <= (act_m == '0);
      pics_m  <= top_m;
    end
  end

  always_comb begin
    case (tsel)
      3'd0:    test_m = {intrq_m, flags_m};
      3'd1:    test_m = res_m[TEST_W-1:0];
      3'd2:    test_m = {2'b00, pics_m};
      default: test_m = '1;
    endcase
  end

  assign bus_m = !ptst_n ? xfidb_in : (!edo_n ? res_m : '0);

  a_bus: assert property (@(posedge sysclk) disable iff (!arst_n) xfidb_out == bus_m)
    else begin
      fails++;
      $error("[FAIL] %0t xfidb_out %h, expected %h", $time, $sampled(xfidb_out),
             $sampled(bus_m));
    end

  a_test: assert property (@(posedge sysclk) disable iff (!arst_n) test == test_m)
    else begin
      fails++;
      $error("[FAIL] %0t test %b, expected %b", $time, $sampled(test), $sampled(test_m));
    end

  a_intrq: assert property (@(posedge sysclk) disable iff (!arst_n) intrq_n == intrq_m)
    else begin
      fails++;
      $error("[FAIL] %0t intrq_n %b, expected %b", $time, $sampled(intrq_n),
             $sampled(intrq_m));
    end

  a_pics: assert property (@(posedge sysclk) disable iff (!arst_n) !intrq_m |-> pics == pics_m)
    else begin
      fails++;
      $error("[FAIL] %0t pics %0d, expected %0d", $time, $sampled(pics), $sampled(pics_m));
    end

endmodule

bind cga cga_checker chk0 (.*);

// File: test/tb_cga.sv
`timescale 1ns/1ps

module tb_cga import cga_pkg::*; ();

  logic                  sysclk;
  logic                  arst_n;
  logic                  cs_valid;
  alu_op_t               cs_op;
  logic [REG_AW-1:0]     cs_ra;
  logic [REG_AW-1:0]     cs_rb;
  bsel_t                 cs_bsel;
  logic [DATA_W-1:0]     cs_cd;
  logic                  cs_wr;
  logic                  cs_ldmask;
  logic [DATA_W-1:0]     xfidb_in;
  logic [DATA_W-1:0]     xfidb_out;
  logic                  edo_n;
  logic                  ptst_n;
  logic [INT_LEVELS-1:0] bint_n;
  logic                  clirq;
  logic                  intrq_n;
  logic [TSEL_W-1:0]     tsel;
  logic [TEST_W-1:0]     test;
  logic [31:0]           lfsr = 32'h3c1d2172;
  int                    timeouts = 0;

  cga dut0 (.*);

  initial begin
    sysclk = 1'b0;
    forever #10 sysclk = ~sysclk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [DATA_W-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[DATA_W-2:0], lfsr[0]};
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge sysclk);
  endtask

  // One microword held for a single cycle
  task automatic issue(input alu_op_t op, input logic [REG_AW-1:0] ra,
                       input logic [REG_AW-1:0] rb, input bsel_t bsel,
                       input logic [DATA_W-1:0] cd, input logic wr, input logic ldm);
    cs_valid  = 1'b1;
    cs_op     = op;
    cs_ra     = ra;
    cs_rb     = rb;
    cs_bsel   = bsel;
    cs_cd     = cd;
    cs_wr     = wr;
    cs_ldmask = ldm;
    @(negedge sysclk);
    cs_valid  = 1'b0;
    cs_wr     = 1'b0;
    cs_ldmask = 1'b0;
  endtask

  task automatic wait_intrq(input logic level, input string what);
    int n;
    n = 0;
    while (intrq_n !== level && n < 20) begin
      @(negedge sysclk);
      n++;
    end
    if (intrq_n !== level) begin
      timeouts++;
      $display("Timeout: intrq_n never went to %b %s", level, what);
    end
  endtask

  initial begin
    logic [DATA_W-1:0] v;
    logic [DATA_W-1:0] cd;
    int                n;
    arst_n    = 1'b0;
    cs_valid  = 1'b0;
    cs_op     = ALU_ADD;
    cs_ra     = '0;
    cs_rb     = '0;
    cs_bsel   = BSEL_REG;
    cs_cd     = '0;
    cs_wr     = 1'b0;
    cs_ldmask = 1'b0;
    xfidb_in  = '0;
    edo_n     = 1'b0;
    ptst_n    = 1'b1;
    bint_n    = '1;
    clirq     = 1'b0;
    tsel      = TSEL_FLAGS;
    repeat (10) @(negedge sysclk);
    arst_n = 1'b1;
    idle(2);

    // Fill every register and read each back well after its write
    for (int r = 0; r < NREGS; r++) begin
      take_bits(16, cd);
      issue(ALU_PASSB, '0, REG_AW'(r), BSEL_CD, cd, 1'b1, 1'b0);
    end
    idle(3);
    for (int r = 0; r < NREGS; r++) begin
      tsel = TSEL_W'(r % 2);
      issue(ALU_PASSA, REG_AW'(r), '0, BSEL_REG, '0, 1'b0, 1'b0);
    end
    idle(2);

    // Register and reserved B sources
    tsel = TSEL_FLAGS;
    issue(ALU_SUB, 4'd5, 4'd5, BSEL_REG, '0, 1'b0, 1'b0); // Zero result sets z
    issue(ALU_ADD, 4'd1, 4'd2, BSEL_REG, '0, 1'b0, 1'b0);
    issue(ALU_OR, 4'd3, '0, bsel_t'(2'd3), 16'hffff, 1'b0, 1'b0);
    idle(2);

    // Back to back with B from constant or bus
    for (int i = 0; i < 64; i++) begin
      take_bits(16, xfidb_in);
      take_bits(16, cd);
      take_bits(8, v);
      tsel = TSEL_W'(i % 4);
      issue(alu_op_t'(v[2:0]), v[6:3], '0, v[7] ? BSEL_BUS : BSEL_CD, cd, 1'b0, 1'b0);
    end
    idle(3);

    issue(ALU_PASSB, '0, '0, BSEL_CD, 16'h000b, 1'b0, 1'b1); // Levels 0, 1 and 3 enabled
    idle(3);
    tsel   = TSEL_PICS;
    bint_n = 5'b00100; // Level 4 pending but masked
    wait_intrq(1'b0, "with levels 0, 1, 3 and 4 requested");
    bint_n = '1;
    n = 0;
    while (intrq_n == 1'b0 && n < 8) begin
      clirq = 1'b1;
      @(negedge sysclk);
      clirq = 1'b0;
      idle(2);
      n++;
    end
    wait_intrq(1'b1, "after clearing the enabled levels");

    ptst_n = 1'b0; // Loopback
    for (int i = 0; i < 8; i++) begin
      take_bits(16, xfidb_in);
      @(negedge sysclk);
    end
    ptst_n = 1'b1;
    edo_n  = 1'b1;
    for (int i = 3; i < 8; i++) begin
      tsel = TSEL_W'(i);
      @(negedge sysclk);
    end
    edo_n = 1'b0;
    idle(2);

    $display("Run complete: %0d assertion failures, %0d timeouts", dut0.chk0.fails, timeouts);
    if (dut0.chk0.fails == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
verilog/cga_pkg.sv
verilog/cga_wrf.sv
verilog/cga_alu.sv
verilog/cga_intr.sv
verilog/cga_pads.sv
verilog/cga.sv
test/cga_checker.sv
test/tb_cga.sv

// File: Makefile
TOP = tb_cga

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f -o sim
	./obj_dir/sim +verilator+error+limit+1000 | tee sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
